// File: rtl/histoSizesPkg.sv
package histoSizesPkg;

    // raw sample from the front end
    parameter int SAMPLE_W = 6;

    // coarse bin index, top bits of a sample
    parameter int BIN_W = 3;
    parameter int BINS_PER_PIXEL = 8;

    // pixels in one acquisition
    parameter int PIXEL_NUM = 2;
    parameter int PIXEL_W = 1;

    // width of one bin counter
    parameter int COUNT_W = 8;

    // defaults for the sequencer parameters
    // the top level may override both
    parameter int SAMPLES_PER_PIXEL_DEF = 2;
    parameter int ACQ_PER_PASS_DEF = 2;

endpackage

// File: rtl/histoTypesPkg.sv
package histoTypesPkg;

    // one strobed sample with its place in the pass
    typedef struct packed {
        logic [histoSizesPkg::PIXEL_W-1:0] pixel;
        logic fine;
        logic last;
        logic [histoSizesPkg::SAMPLE_W-1:0] raw;
    } sampleTag_t;

    // request to bump one bin of one pixel
    typedef struct packed {
        logic [histoSizesPkg::PIXEL_W-1:0] pixel;
        logic [histoSizesPkg::BIN_W-1:0] bin;
        logic last;
        logic fine;
    } binReq_t;

    // updated count of a bin
    typedef struct packed {
        logic [histoSizesPkg::PIXEL_W-1:0] pixel;
        logic [histoSizesPkg::BIN_W-1:0] bin;
        logic [histoSizesPkg::COUNT_W-1:0] count;
        logic fine;
    } binCount_t;

    // lower window edge, one per pixel
    typedef logic [histoSizesPkg::PIXEL_NUM-1:0][histoSizesPkg::SAMPLE_W-1:0] windowLow_t;

endpackage

// File: rtl/sampleSequencer.sv
`timescale 1ns/10ps

module sampleSequencer #(
    parameter int unsigned samplesPerPixel = histoSizesPkg::SAMPLES_PER_PIXEL_DEF,
    parameter int unsigned acqPerPass = histoSizesPkg::ACQ_PER_PASS_DEF
) (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic [histoSizesPkg::SAMPLE_W-1:0] sample,
    output histoTypesPkg::sampleTag_t tag,
    output logic tagValid
);
    import histoSizesPkg::*;

    // a single-entry counter still needs one bit
    localparam int sampleCntW = (samplesPerPixel > 1) ? $clog2(samplesPerPixel) : 1;
    localparam int acqCntW = (acqPerPass > 1) ? $clog2(acqPerPass) : 1;

    logic [sampleCntW-1:0] sampleCnt;
    logic [PIXEL_W-1:0] pixelCnt;
    logic [acqCntW-1:0] acqCnt;
    logic passFlag;
    logic lastSample;
    logic lastPixel;
    logic lastAcq;
    logic lastOfPass;

    // wrap points of the three nested counters
    assign lastSample = (sampleCnt == sampleCntW'(samplesPerPixel - 1));
    assign lastPixel = (pixelCnt == PIXEL_W'(PIXEL_NUM - 1));
    assign lastAcq = (acqCnt == acqCntW'(acqPerPass - 1));
    assign lastOfPass = lastSample && lastPixel && lastAcq;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            passFlag <= 1'b0;
            tag <= '0;
            tagValid <= 1'b0;
        end else begin
            tagValid <= wrEn;
            // payload follows every cycle so the pass flag reaches the output
            // even while no samples arrive
            tag.pixel <= pixelCnt;
            tag.fine <= passFlag;
            tag.last <= wrEn && lastOfPass;
            tag.raw <= sample;
            if (wrEn) begin
                if (lastSample) begin
                    sampleCnt <= '0;
                    if (lastPixel) begin
                        pixelCnt <= '0;
                        if (lastAcq) begin
                            acqCnt <= '0;
                            // coarse and fine passes alternate
                            passFlag <= ~passFlag;
                        end else begin
                            acqCnt <= acqCnt + 1'b1;
                        end
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

    // host keeps quiet until the pass clear and the window latch are through
    quietAfterPass: assert property (
        @(posedge clk) disable iff (!combin_res)
        (tagValid && tag.last) |-> !wrEn [*3]
    );

endmodule

// File: rtl/peakWindowRegs.sv
`timescale 1ns/10ps

module peakWindowRegs (
    input  logic clk,
    input  logic combin_res,
    input  logic [histoSizesPkg::PIXEL_NUM-1:0][histoSizesPkg::BIN_W-1:0] peakBins,
    input  logic peakDone,
    output histoTypesPkg::windowLow_t windowLow
);
    import histoSizesPkg::*;
    import histoTypesPkg::*;

    // window spans one coarse bin, centred on the peak bin's lower edge
    localparam int halfWin = BINS_PER_PIXEL / 2;
    localparam int maxLow = (1 << SAMPLE_W) - BINS_PER_PIXEL;
    localparam int shiftW = SAMPLE_W - BIN_W;

    logic [SAMPLE_W-1:0] center [PIXEL_NUM];
    windowLow_t lowNext;

    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            // peak bin back into sample units
            center[p] = SAMPLE_W'(peakBins[p]) << shiftW;
            if (center[p] < SAMPLE_W'(halfWin)) begin
                // peak near zero, pin the window to the bottom
                lowNext[p] = '0;
            end else if ((center[p] - SAMPLE_W'(halfWin)) > SAMPLE_W'(maxLow)) begin
                // would run past full scale
                lowNext[p] = SAMPLE_W'(maxLow);
            end else begin
                lowNext[p] = center[p] - SAMPLE_W'(halfWin);
            end
        end
    end

    // edges hold for the whole fine pass
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windowLow <= '0;
        end else if (peakDone) begin
            windowLow <= lowNext;
        end
    end

endmodule

// File: rtl/binMapper.sv
`timescale 1ns/10ps

module binMapper (
    input  logic clk,
    input  logic combin_res,
    input  histoTypesPkg::sampleTag_t tag,
    input  logic tagValid,
    input  histoTypesPkg::windowLow_t windowLow,
    output histoTypesPkg::binReq_t req,
    output logic reqValid
);
    import histoSizesPkg::*;

    logic [SAMPLE_W-1:0] low;
    logic [SAMPLE_W-1:0] offset;
    logic [BIN_W-1:0] binNext;

    always_comb begin
        low = windowLow[tag.pixel];
        // distance from the lower edge
        offset = tag.raw - low;
        if (!tag.fine) begin
            // coarse, top bits only
            binNext = tag.raw[SAMPLE_W-1 -: BIN_W];
        end else if ((tag.raw >= low) && (offset < SAMPLE_W'(BINS_PER_PIXEL))) begin
            binNext = offset[BIN_W-1:0];
        end else begin
            // outside the window, lumped into bin 0
            binNext = '0;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            req <= '0;
            reqValid <= 1'b0;
        end else begin
            reqValid <= tagValid;
            req.pixel <= tag.pixel;
            req.bin <= binNext;
            req.last <= tagValid && tag.last;
            req.fine <= tag.fine;
        end
    end

endmodule

// File: rtl/histogramRam.sv
`timescale 1ns/10ps

module histogramRam (
    input  logic clk,
    input  logic combin_res,
    input  histoTypesPkg::binReq_t req,
    input  logic reqValid,
    output histoTypesPkg::binCount_t result,
    output logic countValid,
    output logic passDone
);
    import histoSizesPkg::*;

    localparam int depth = PIXEL_NUM * BINS_PER_PIXEL;

    // counters of all pixels, pixel index in the upper address bits
    logic [COUNT_W-1:0] mem [depth];
    // set on first touch, a cleared flag reads as count 0
    logic [depth-1:0] binValid;
    logic [PIXEL_W+BIN_W-1:0] addr;
    logic [COUNT_W-1:0] curCount;

    assign addr = {req.pixel, req.bin};

    // stale contents hidden until the bin is written again
    assign curCount = binValid[addr] ? mem[addr] : '0;

    assign result = '{
        pixel: req.pixel,
        bin: req.bin,
        count: curCount + COUNT_W'(1),
        fine: req.fine
    };
    assign countValid = reqValid;
    assign passDone = reqValid && req.last;

    // read-modify-write within one cycle
    // the next request always sees the updated value
    always_ff @(posedge clk) begin
        if (reqValid) begin
            mem[addr] <= result.count;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (passDone) begin
            // lazy clear, whole histogram restarts from zero
            binValid <= '0;
        end else if (reqValid) begin
            binValid[addr] <= 1'b1;
        end
    end

    // pass length must fit the counter width
    noCountWrap: assert property (
        @(posedge clk) disable iff (!combin_res)
        reqValid |-> (curCount != {COUNT_W{1'b1}})
    );

endmodule

// File: rtl/peakTracker.sv
`timescale 1ns/10ps

module peakTracker (
    input  logic clk,
    input  logic combin_res,
    input  histoTypesPkg::binCount_t result,
    input  logic countValid,
    input  logic passDone,
    output logic [histoSizesPkg::PIXEL_NUM-1:0][histoSizesPkg::BIN_W-1:0] peakBins,
    output logic peakDone
);
    import histoSizesPkg::*;

    // highest count seen so far per pixel
    logic [COUNT_W-1:0] recentMax [PIXEL_NUM];
    logic coarseHit;

    // only the coarse pass picks the peak
    assign coarseHit = countValid && !result.fine;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakDone <= 1'b0;
            peakBins <= '0;
            for (int p = 0; p < PIXEL_NUM; p++) begin
                recentMax[p] <= '0;
            end
        end else begin
            // one cycle after the coarse pass closes
            peakDone <= passDone && !result.fine;
            if (peakDone) begin
                // peak bins stay, maxima restart for the next coarse pass
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    recentMax[p] <= '0;
                end
            end else if (coarseHit && (result.count > recentMax[result.pixel])) begin
                // strictly greater, first bin to reach a count wins ties
                recentMax[result.pixel] <= result.count;
                peakBins[result.pixel] <= result.bin;
            end
        end
    end

    // host gap keeps counts away from the clearing cycle
    noCountOnClear: assert property (
        @(posedge clk) disable iff (!combin_res)
        peakDone |-> !countValid
    );

endmodule

// File: rtl/peakHistogramTop.sv
`timescale 1ns/10ps

module peakHistogramTop #(
    parameter int unsigned samplesPerPixel = histoSizesPkg::SAMPLES_PER_PIXEL_DEF,
    parameter int unsigned acqPerPass = histoSizesPkg::ACQ_PER_PASS_DEF
) (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic [histoSizesPkg::SAMPLE_W-1:0] sample,
    output histoTypesPkg::binCount_t result,
    output logic countValid,
    output logic passFine,
    output logic [histoSizesPkg::PIXEL_NUM-1:0][histoSizesPkg::BIN_W-1:0] peakBins,
    output logic peakDone,
    output logic passDone
);
    import histoTypesPkg::*;

    sampleTag_t tag;
    logic tagValid;
    binReq_t req;
    logic reqValid;
    windowLow_t windowLow;

    // pass of the newest result, flips right after passDone
    assign passFine = result.fine;

    sampleSequencer #(
        .samplesPerPixel(samplesPerPixel),
        .acqPerPass(acqPerPass)
    ) sampleSequencer_inst (
        .clk(clk),
        .combin_res(combin_res),
        .wrEn(wrEn),
        .sample(sample),
        .tag(tag),
        .tagValid(tagValid)
    );

    binMapper binMapper_inst (
        .clk(clk),
        .combin_res(combin_res),
        .tag(tag),
        .tagValid(tagValid),
        .windowLow(windowLow),
        .req(req),
        .reqValid(reqValid)
    );

    histogramRam histogramRam_inst (
        .clk(clk),
        .combin_res(combin_res),
        .req(req),
        .reqValid(reqValid),
        .result(result),
        .countValid(countValid),
        .passDone(passDone)
    );

    peakTracker peakTracker_inst (
        .clk(clk),
        .combin_res(combin_res),
        .result(result),
        .countValid(countValid),
        .passDone(passDone),
        .peakBins(peakBins),
        .peakDone(peakDone)
    );

    peakWindowRegs peakWindowRegs_inst (
        .clk(clk),
        .combin_res(combin_res),
        .peakBins(peakBins),
        .peakDone(peakDone),
        .windowLow(windowLow)
    );

endmodule

// File: test/peakHistogramTb.sv
`timescale 1ns/10ps

module peakHistogramTb;
    import histoSizesPkg::*;
    import histoTypesPkg::*;

    localparam int spp = SAMPLES_PER_PIXEL_DEF;
    localparam int app = ACQ_PER_PASS_DEF;
    // one burst of the data file per pass
    localparam int passLen = spp * app * PIXEL_NUM;
    localparam int passNum = 2;
    localparam int sampleNum = passLen * passNum;
    localparam int timeoutCycles = 12;

    logic clk;
    logic combin_res;
    logic wrEn;
    logic [SAMPLE_W-1:0] sample;
    binCount_t result;
    logic countValid;
    logic passFine;
    logic [PIXEL_NUM-1:0][BIN_W-1:0] peakBins;
    logic peakDone;
    logic passDone;

    // three words per sample for raw value, expected count and expected bin
    logic [7:0] testVec [0:3*sampleNum-1];
    int errorCount;
    int testCount;
    int failedTests;
    int startErrors;
    logic dataOk;

    peakHistogramTop #(
        .samplesPerPixel(spp),
        .acqPerPass(app)
    ) peakHistogramTop_inst (
        .clk(clk),
        .combin_res(combin_res),
        .wrEn(wrEn),
        .sample(sample),
        .result(result),
        .countValid(countValid),
        .passFine(passFine),
        .peakBins(peakBins),
        .peakDone(peakDone),
        .passDone(passDone)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic reportMismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] expected);
        $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
        errorCount++;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    // bursts of spp samples per pixel with pixels in turn
    function automatic int pixelOf(input int sIdx);
        return (sIdx / spp) % PIXEL_NUM;
    endfunction

    // first bin to reach the highest count in the file's counts
    function automatic logic [BIN_W-1:0] expectedPeak(input int base, input int pixel);
        int best;
        logic [BIN_W-1:0] bestBin;
        best = 0;
        bestBin = '0;
        for (int i = 0; i < passLen; i++) begin
            if ((pixelOf(i) == pixel) && (int'(testVec[3*(base+i)+1]) > best)) begin
                best = testVec[3*(base+i)+1];
                bestBin = testVec[3*(base+i)+2][BIN_W-1:0];
            end
        end
        return bestBin;
    endfunction

    task automatic checkReset();
        if (countValid !== 1'b0) reportMismatch("countValid", countValid, 1'b0);
        if (passDone !== 1'b0) reportMismatch("passDone", passDone, 1'b0);
        if (peakDone !== 1'b0) reportMismatch("peakDone", peakDone, 1'b0);
        if (passFine !== 1'b0) reportMismatch("passFine", passFine, 1'b0);
        if (peakBins !== '0) reportMismatch("peakBins", peakBins, '0);
    endtask

    // result of sample sIdx is due two cycles after its strobe
    task automatic checkResultCycle(input int base, input int sIdx, input logic fine);
        logic expValid;
        logic expDone;
        int e;
        expValid = (sIdx >= 0) && (sIdx < passLen);
        expDone = expValid && (sIdx == passLen - 1);
        e = 3 * (base + sIdx);
        if (countValid !== expValid) reportMismatch("countValid", countValid, expValid);
        if (passDone !== expDone) reportMismatch("passDone", passDone, expDone);
        if (peakDone !== 1'b0) reportMismatch("peakDone", peakDone, 1'b0);
        // pass flag flips only after passDone
        if (passFine !== fine) reportMismatch("passFine", passFine, fine);
        if (expValid && countValid) begin
            if (result.pixel !== PIXEL_W'(pixelOf(sIdx))) begin
                reportMismatch("result.pixel", result.pixel, pixelOf(sIdx));
            end
            if (result.bin !== testVec[e+2][BIN_W-1:0]) begin
                reportMismatch("result.bin", result.bin, testVec[e+2]);
            end
            if (result.count !== testVec[e+1]) begin
                reportMismatch("result.count", result.count, testVec[e+1]);
            end
            if (result.fine !== fine) reportMismatch("result.fine", result.fine, fine);
        end
    endtask

    // one burst and then idle until passDone or timeout
    task automatic runPass(input int passIdx);
        int base;
        int c;
        logic fine;
        logic seenDone;
        base = passIdx * passLen;
        fine = (passIdx % 2) == 1;
        seenDone = 1'b0;
        c = 0;
        while (!seenDone && (c < passLen + timeoutCycles)) begin
            @(posedge clk);
            if (c < passLen) begin
                wrEn <= 1'b1;
                sample <= testVec[3*(base+c)][SAMPLE_W-1:0];
            end else begin
                wrEn <= 1'b0;
            end
            @(negedge clk);
            checkResultCycle(base, c - 2, fine);
            seenDone = (passDone === 1'b1);
            c++;
        end
        if (!seenDone) begin
            $display("passDone never came within %0d cycles of the burst", timeoutCycles);
            errorCount++;
        end
    endtask

    // cycle after passDone is the third idle cycle of the gap
    task automatic closePass(input int passIdx);
        logic fine;
        int coarseBase;
        logic [BIN_W-1:0] expPeak;
        fine = (passIdx % 2) == 1;
        coarseBase = (fine ? passIdx - 1 : passIdx) * passLen;
        @(posedge clk);
        wrEn <= 1'b0;
        @(negedge clk);
        // peakDone only after a coarse pass
        if (peakDone !== !fine) reportMismatch("peakDone", peakDone, !fine);
        if (passFine !== !fine) reportMismatch("passFine", passFine, !fine);
        if (countValid !== 1'b0) reportMismatch("countValid", countValid, 1'b0);
        // peak bins hold through the fine pass
        for (int px = 0; px < PIXEL_NUM; px++) begin
            expPeak = expectedPeak(coarseBase, px);
            if (peakBins[px] !== expPeak) begin
                reportMismatch($sformatf("peakBins[%0d]", px), peakBins[px], expPeak);
            end
        end
    endtask

    initial begin
        combin_res = 1'b0;
        wrEn = 1'b0;
        sample = '0;
        errorCount = 0;
        testCount = 0;
        failedTests = 0;
        $readmemh("test/peakHistogram_testdata.txt", testVec);
        dataOk = 1'b1;
        for (int i = 0; i < 3 * sampleNum; i++) begin
            if ($isunknown(testVec[i])) dataOk = 1'b0;
        end
        if (!dataOk) begin
            $display("test data file is missing or holds too few entries");
            errorCount++;
        end
        repeat (2) @(posedge clk);
        combin_res <= 1'b1;
        @(negedge clk);
        startErrors = errorCount;
        checkReset();
        finishTest("reset state", startErrors);
        if (dataOk) begin
            startErrors = errorCount;
            runPass(0);
            finishTest("coarse binning", startErrors);
            startErrors = errorCount;
            closePass(0);
            finishTest("peak choice and pass toggle", startErrors);
            startErrors = errorCount;
            runPass(1);
            finishTest("fine window binning and pass clear", startErrors);
            startErrors = errorCount;
            closePass(1);
            finishTest("fine pass end and toggle back", startErrors);
        end
        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: test/peakHistogram_testdata.txt
// raw sample, expected count, expected bin, all hex, one sample per line
// pixel 0 peaks at bin 0, pixel 1 ties bins 7 and 6, first to reach 2 wins
02 01 0
1A 01 3
3C 01 7
30 01 6
05 02 0
21 01 4
3F 02 7
33 02 6
03 01 3
09 01 0
35 01 1
3E 01 0
00 02 0
07 01 7
34 02 0
2A 03 0

// File: vlog.f
rtl/histoSizesPkg.sv
rtl/histoTypesPkg.sv
rtl/sampleSequencer.sv
rtl/peakWindowRegs.sv
rtl/binMapper.sv
rtl/histogramRam.sv
rtl/peakTracker.sv
rtl/peakHistogramTop.sv
test/peakHistogramTb.sv
